//--- hw/int_alu_cfg.svh
`ifndef INT_ALU_CFG_SVH
`define INT_ALU_CFG_SVH

// ------------------------------------------------------------
// Widths of the integer ALU lane
// ------------------------------------------------------------

// Operand and result word
`define INT_ALU_XLEN 64

// Flag vector, from the top bit x o s z c
`define INT_ALU_FLAGS_W 5

// Opcode field as it arrives from the issue port
`define INT_ALU_OP_W 8

`endif

//--- hw/int_alu_pkg.sv
`include "int_alu_cfg.svh"

package int_alu_pkg;

  // ------------------------------------------------------------
  // Datapath words
  // ------------------------------------------------------------
  typedef logic [`INT_ALU_XLEN-1:0] data_t;
  typedef logic [`INT_ALU_FLAGS_W-1:0] flags_t;

  localparam int FLAG_C = 0;  // Carry out, or borrow on subtract
  localparam int FLAG_Z = 1;
  localparam int FLAG_S = 2;
  localparam int FLAG_O = 3;  // Signed overflow
  localparam int FLAG_X = 4;  // Illegal opcode seen

  // ------------------------------------------------------------
  // Opcodes, every other encoding decodes as illegal
  // ------------------------------------------------------------
  typedef enum logic [`INT_ALU_OP_W-1:0] {
    OP_ADD64 = 8'h01,
    OP_ADD32 = 8'h02,
    OP_SUB64 = 8'h03,
    OP_SUB32 = 8'h04,
    OP_ADC64 = 8'h05,
    OP_CMP64 = 8'h06,
    OP_CMP32 = 8'h07,
    OP_AND   = 8'h10,
    OP_OR    = 8'h11,
    OP_XOR   = 8'h12,
    OP_SHL64 = 8'h20,
    OP_SHR64 = 8'h21,
    OP_SAR64 = 8'h22,
    OP_SHL32 = 8'h24,
    OP_SHR32 = 8'h25,
    OP_SAR32 = 8'h26
  } opcode_t;

  // Where an operand comes from at the issue edge
  typedef enum logic [2:0] {
    SRC_PORT    = 3'd0,
    SRC_EXT     = 3'd1,
    SRC_EXT_OLD = 3'd2,
    SRC_OWN     = 3'd3,
    SRC_OWN_OLD = 3'd4
  } fwd_src_t;

  typedef enum logic [1:0] {
    UNIT_ADD   = 2'd0,
    UNIT_LOGIC = 2'd1,
    UNIT_SHIFT = 2'd2
  } alu_unit_t;

  localparam logic [1:0] LOGIC_AND = 2'd0;
  localparam logic [1:0] LOGIC_OR  = 2'd1;
  localparam logic [1:0] LOGIC_XOR = 2'd2;

  // Decoded control, passed from the forward stage to execute
  typedef struct packed {
    alu_unit_t  unit;
    logic       is_sub;
    logic       use_carry;
    logic       is_word;        // 32-bit width
    logic       arith;          // Sign fill on right shift
    logic       dir_right;
    logic [1:0] logic_fn;
    logic       writes_result;
    logic       illegal;
  } alu_ctl_t;

endpackage

//--- hw/operand_forward.sv
`timescale 1ns/1ns

module operand_forward #(
  parameter type payload_t = logic
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  int_alu_pkg::fwd_src_t sel,
  input  payload_t              port_val,
  input  payload_t              ext_val,
  input  payload_t              own_val,
  output payload_t              operand
);
  import int_alu_pkg::*;

  payload_t ext_old;  // External bus as it was one edge back
  payload_t own_old;  // Own result as it was one edge back
  payload_t picked;

  // ------------------------------------------------------------
  // Bypass select
  // ------------------------------------------------------------
  always_comb begin
    case (sel)
      SRC_EXT:     picked = ext_val;
      SRC_EXT_OLD: picked = ext_old;
      SRC_OWN:     picked = own_val;
      SRC_OWN_OLD: picked = own_old;
      default:     picked = port_val;
    endcase
  end

  // History copies shift on every edge, whether or not an op issues
  always_ff @(posedge clk) begin
    ext_old <= ext_val;
    own_old <= own_val;
  end

  // Operand register feeding the execute stage
  always_ff @(posedge clk) begin
    operand <= picked;
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Codes 5 to 7 would silently fall back to the issue port value
  a_sel_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    sel inside {SRC_PORT, SRC_EXT, SRC_EXT_OLD, SRC_OWN, SRC_OWN_OLD}
  ) else $error("operand_forward: select code %0d is not a forwarding source", sel);

endmodule

//--- hw/op_decode.sv
`timescale 1ns/1ns

module op_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid,
  input  int_alu_pkg::opcode_t  issue_op,
  output int_alu_pkg::alu_ctl_t ctl,
  output logic                  ctl_valid
);
  import int_alu_pkg::*;

  alu_ctl_t ctl_next;

  // ------------------------------------------------------------
  // Opcode translation
  // ------------------------------------------------------------
  always_comb begin
    ctl_next = '0;
    ctl_next.unit = UNIT_ADD;
    ctl_next.writes_result = 1'b1;
    case (issue_op)
      OP_ADD64: ;
      OP_ADD32: ctl_next.is_word = 1'b1;
      OP_SUB64: ctl_next.is_sub = 1'b1;
      OP_SUB32: begin
        ctl_next.is_sub = 1'b1;
        ctl_next.is_word = 1'b1;
      end
      OP_ADC64: ctl_next.use_carry = 1'b1;  // Carry taken from the flags operand
      OP_CMP64: begin
        ctl_next.is_sub = 1'b1;
        ctl_next.writes_result = 1'b0;
      end
      OP_CMP32: begin
        ctl_next.is_sub = 1'b1;
        ctl_next.is_word = 1'b1;
        ctl_next.writes_result = 1'b0;
      end
      OP_AND, OP_OR, OP_XOR: begin
        ctl_next.unit = UNIT_LOGIC;
        ctl_next.logic_fn = (issue_op == OP_OR)  ? LOGIC_OR :
                            (issue_op == OP_XOR) ? LOGIC_XOR : LOGIC_AND;
      end
      OP_SHL64, OP_SHR64, OP_SAR64, OP_SHL32, OP_SHR32, OP_SAR32: begin
        ctl_next.unit = UNIT_SHIFT;
        ctl_next.is_word = (issue_op == OP_SHL32) || (issue_op == OP_SHR32) ||
                           (issue_op == OP_SAR32);
        ctl_next.dir_right = (issue_op != OP_SHL64) && (issue_op != OP_SHL32);
        ctl_next.arith = (issue_op == OP_SAR64) || (issue_op == OP_SAR32);
      end
      default: begin
        ctl_next.illegal = 1'b1;
        ctl_next.writes_result = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Stage register, lines up with the forwarded operands
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctl_valid <= 1'b0;
      ctl <= '0;
    end else begin
      ctl_valid <= issue_valid;
      ctl <= ctl_next;
    end
  end

  // A decoded op never both writes a result and reports itself illegal
  a_illegal_no_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    ctl_valid |-> !(ctl.illegal && ctl.writes_result)
  ) else $error("op_decode: op decoded as illegal with a result write");

endmodule

//--- hw/alu_exec.sv
`timescale 1ns/1ns
`include "int_alu_cfg.svh"

module alu_exec (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ctl_valid,
  input  int_alu_pkg::alu_ctl_t ctl,
  input  int_alu_pkg::data_t    a,
  input  int_alu_pkg::data_t    b,
  input  int_alu_pkg::flags_t   flags_in,
  output int_alu_pkg::data_t    res,
  output int_alu_pkg::flags_t   res_flags,
  output logic                  res_valid,
  output logic                  res_wen
);
  import int_alu_pkg::*;

  localparam int XLEN = `INT_ALU_XLEN;
  localparam int HALF = XLEN / 2;
  localparam int SHW  = $clog2(XLEN);

  data_t           b_inv;
  logic            carry_in;
  logic [XLEN:0]   sum_full;
  data_t           sum;
  logic            carry_w;
  logic            ovf_w;
  data_t           logic_res;
  logic [SHW-1:0]  sh_amt;
  data_t           sh_src;
  logic            sh_fill;
  logic [2*XLEN-1:0] sh_wide;
  data_t           shift_res;
  data_t           raw_res;
  data_t           res_next;
  flags_t          flags_next;

  // ------------------------------------------------------------
  // Adder, shared by add, adc, sub and cmp
  // ------------------------------------------------------------
  always_comb begin
    b_inv = ctl.is_sub ? ~b : b;
    carry_in = ctl.is_sub | (ctl.use_carry & flags_in[FLAG_C]);
    sum_full = {1'b0, a} + {1'b0, b_inv} + {{XLEN{1'b0}}, carry_in};
    sum = sum_full[XLEN-1:0];
    if (ctl.is_word) begin
      carry_w = sum[HALF] ^ a[HALF] ^ b_inv[HALF];  // Carry into bit 32 is the word carry out
      ovf_w = (a[HALF-1] == b_inv[HALF-1]) && (sum[HALF-1] != a[HALF-1]);
    end else begin
      carry_w = sum_full[XLEN];
      ovf_w = (a[XLEN-1] == b_inv[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
    end
  end

  always_comb begin
    case (ctl.logic_fn)
      LOGIC_OR:  logic_res = a | b;
      LOGIC_XOR: logic_res = a ^ b;
      default:   logic_res = a & b;
    endcase
  end

  // ------------------------------------------------------------
  // Shifter, amount taken modulo the operation width
  // ------------------------------------------------------------
  always_comb begin
    sh_amt = ctl.is_word ? {1'b0, b[SHW-2:0]} : b[SHW-1:0];
    sh_src = ctl.is_word ? {{HALF{ctl.arith & a[HALF-1]}}, a[HALF-1:0]} : a;
    sh_fill = ctl.arith & sh_src[XLEN-1];
    sh_wide = {{XLEN{sh_fill}}, sh_src} >> sh_amt;
    shift_res = ctl.dir_right ? sh_wide[XLEN-1:0] : sh_src << sh_amt;
  end

  // Result select and flags
  always_comb begin
    case (ctl.unit)
      UNIT_LOGIC: raw_res = logic_res;
      UNIT_SHIFT: raw_res = shift_res;
      default:    raw_res = sum;
    endcase
    res_next = ctl.is_word ? {{HALF{1'b0}}, raw_res[HALF-1:0]} : raw_res;
    flags_next = '0;
    if (ctl.illegal) begin
      flags_next[FLAG_X] = 1'b1;
    end else begin
      flags_next[FLAG_S] = ctl.is_word ? raw_res[HALF-1] : raw_res[XLEN-1];
      flags_next[FLAG_Z] = (res_next == '0);
      if (ctl.unit == UNIT_ADD) begin
        flags_next[FLAG_C] = carry_w ^ ctl.is_sub;  // Borrow is the inverted carry
        flags_next[FLAG_O] = ovf_w;
      end
    end
  end

  // ------------------------------------------------------------
  // Result register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res_wen <= 1'b0;
      res <= '0;
      res_flags <= '0;
    end else begin
      res_valid <= ctl_valid;
      res_wen <= ctl_valid & ctl.writes_result;
      if (ctl_valid) begin
        res_flags <= flags_next;
        if (ctl.writes_result) begin
          res <= res_next;  // Compare and illegal ops keep the old value
        end
      end
    end
  end

  a_wen_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    res_wen |-> res_valid
  ) else $error("alu_exec: result write without a valid result");

  a_outputs_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({res_valid, res_wen, res, res_flags})
  ) else $error("alu_exec: unknown value on the result bus");

endmodule

//--- hw/int_alu_lane.sv
`timescale 1ns/1ns

module int_alu_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid,
  input  int_alu_pkg::opcode_t  issue_op,
  input  int_alu_pkg::data_t    a_val,
  input  int_alu_pkg::data_t    b_val,
  input  int_alu_pkg::flags_t   flags_val,
  input  int_alu_pkg::fwd_src_t a_src,
  input  int_alu_pkg::fwd_src_t b_src,
  input  int_alu_pkg::fwd_src_t f_src,
  input  int_alu_pkg::data_t    ext_res,
  input  int_alu_pkg::flags_t   ext_flags,
  output int_alu_pkg::data_t    res,
  output int_alu_pkg::flags_t   res_flags,
  output logic                  res_valid,
  output logic                  res_wen
);
  import int_alu_pkg::*;

  data_t    a_op;
  data_t    b_op;
  flags_t   f_op;
  alu_ctl_t ctl;
  logic     ctl_valid;

  // ------------------------------------------------------------
  // Forward and decode stage
  // ------------------------------------------------------------
  operand_forward #(.payload_t(data_t)) fwd_a (
    .clk      (clk),
    .rst_n    (rst_n),
    .sel      (a_src),
    .port_val (a_val),
    .ext_val  (ext_res),
    .own_val  (res),
    .operand  (a_op)
  );

  operand_forward #(.payload_t(data_t)) fwd_b (
    .clk      (clk),
    .rst_n    (rst_n),
    .sel      (b_src),
    .port_val (b_val),
    .ext_val  (ext_res),
    .own_val  (res),
    .operand  (b_op)
  );

  // Flags follow the same bypass paths as the data words
  operand_forward #(.payload_t(flags_t)) fwd_f (
    .clk      (clk),
    .rst_n    (rst_n),
    .sel      (f_src),
    .port_val (flags_val),
    .ext_val  (ext_flags),
    .own_val  (res_flags),
    .operand  (f_op)
  );

  op_decode decode0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .ctl         (ctl),
    .ctl_valid   (ctl_valid)
  );

  // Execute stage
  alu_exec exec0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl_valid (ctl_valid),
    .ctl       (ctl),
    .a         (a_op),
    .b         (b_op),
    .flags_in  (f_op),
    .res       (res),
    .res_flags (res_flags),
    .res_valid (res_valid),
    .res_wen   (res_wen)
  );

endmodule

//--- bench/int_alu_lane_tb.sv
`timescale 1ns/1ns

module int_alu_lane_tb;
  import int_alu_pkg::*;

  logic clk = 1'b0;
  logic rst_n, issue_valid, res_valid, res_wen;
  opcode_t issue_op;
  fwd_src_t a_src, b_src, f_src;
  data_t a_val, b_val, ext_res, res;
  flags_t flags_val, ext_flags, res_flags;
  int seed = 32'h1361;
  int errors = 0;
  int tests_run = 0;
  int issued, retired;
  // Reference pipeline, one op between issue and execute
  logic s1_valid, exp_valid, exp_wen, seen_issue;
  opcode_t s1_op;
  data_t s1_a, s1_b, exp_res, ext_old, own_old;
  flags_t s1_f, exp_flags, extf_old, ownf_old;
  opcode_t arith_ops[7] = '{OP_ADD64, OP_ADD32, OP_SUB64, OP_SUB32, OP_ADC64, OP_CMP64, OP_CMP32};
  opcode_t lsh_ops[9] = '{OP_AND, OP_OR, OP_XOR, OP_SHL64, OP_SHR64, OP_SAR64,
                          OP_SHL32, OP_SHR32, OP_SAR32};

  int_alu_lane dut0 (
    .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_op(issue_op),
    .a_val(a_val), .b_val(b_val), .flags_val(flags_val),
    .a_src(a_src), .b_src(b_src), .f_src(f_src), .ext_res(ext_res), .ext_flags(ext_flags),
    .res(res), .res_flags(res_flags), .res_valid(res_valid), .res_wen(res_wen)
  );

  always #50 clk = ~clk;

  function automatic data_t rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic data_t pick(input fwd_src_t s, input data_t port, input data_t ext,
                                 input data_t ext_o, input data_t own, input data_t own_o);
    case (s)
      SRC_EXT:     return ext;
      SRC_EXT_OLD: return ext_o;
      SRC_OWN:     return own;
      SRC_OWN_OLD: return own_o;
      default:     return port;
    endcase
  endfunction

  task automatic model_op(input opcode_t op, input data_t a, input data_t b, input flags_t f,
                          inout data_t r, output flags_t fl, output logic wen);
    logic word;
    int w;
    int amt;
    logic [64:0] sum;
    data_t mask, v, sx;
    word = op inside {OP_ADD32, OP_SUB32, OP_CMP32, OP_SHL32, OP_SHR32, OP_SAR32};
    w = word ? 32 : 64;
    mask = word ? 64'h0000_0000_ffff_ffff : {64{1'b1}};
    amt = b % w;
    sx = word ? {{32{a[31]}}, a[31:0]} : a;
    fl = '0;
    wen = 1'b1;
    v = '0;
    case (op)
      OP_ADD64, OP_ADD32, OP_ADC64: begin
        sum = {1'b0, a & mask} + {1'b0, b & mask} + 65'(f[0] & (op == OP_ADC64));
        v = sum[63:0] & mask;
        fl[0] = sum[w];
        fl[3] = (a[w-1] == b[w-1]) && (v[w-1] != a[w-1]);
      end
      OP_SUB64, OP_SUB32, OP_CMP64, OP_CMP32: begin
        v = ((a & mask) - (b & mask)) & mask;
        fl[0] = (a & mask) < (b & mask);  // Borrow
        fl[3] = (a[w-1] != b[w-1]) && (v[w-1] != a[w-1]);
        wen = !(op inside {OP_CMP64, OP_CMP32});
      end
      OP_AND: v = a & b;
      OP_OR:  v = a | b;
      OP_XOR: v = a ^ b;
      OP_SHL64, OP_SHL32: v = ((a & mask) << amt) & mask;
      OP_SHR64, OP_SHR32: v = (a & mask) >> amt;
      OP_SAR64, OP_SAR32: begin
        v = $signed(sx) >>> amt;
        v = v & mask;
      end
      default: wen = 1'b0;
    endcase
    if (!(op inside {arith_ops, lsh_ops})) begin
      fl = 5'b10000;
    end else begin
      fl[2] = v[w-1];
      fl[1] = (v == '0);
    end
    if (wen) r = v;
  endtask

  always @(posedge clk) begin : ref_model
    data_t own_now;
    flags_t ownf_now;
    own_now = exp_res;
    ownf_now = exp_flags;
    if (!rst_n) begin
      {s1_valid, exp_valid, exp_wen, seen_issue} = '0;
      exp_res = '0;
      exp_flags = '0;
    end else begin
      exp_valid = s1_valid;
      exp_wen = 1'b0;
      if (s1_valid) model_op(s1_op, s1_a, s1_b, s1_f, exp_res, exp_flags, exp_wen);
      s1_valid = issue_valid;
      s1_op = issue_op;
      s1_a = pick(a_src, a_val, ext_res, ext_old, own_now, own_old);
      s1_b = pick(b_src, b_val, ext_res, ext_old, own_now, own_old);
      s1_f = flags_t'(pick(f_src, 64'(flags_val), 64'(ext_flags), 64'(extf_old),
                           64'(ownf_now), 64'(ownf_old)));
      seen_issue = seen_issue | issue_valid;
    end
    ext_old = ext_res;
    extf_old = ext_flags;
    own_old = own_now;
    ownf_old = ownf_now;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      issued <= 0;
      retired <= 0;
    end else begin
      issued <= issued + issue_valid;
      retired <= retired + res_valid;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
  endtask

  a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_issue |-> !res_valid && !res_wen && res == '0 && res_flags == '0)
    else report_fail("outputs not idle and zero after reset");
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |-> ##2 res_valid) else report_fail("res_valid missing 2 cycles after issue");
  a_valid_wen: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid == exp_valid && res_wen == exp_wen)
    else report_fail($sformatf("valid/wen %b%b, expected %b%b", res_valid, res_wen,
                               exp_valid, exp_wen));
  a_result: assert property (@(posedge clk) disable iff (!rst_n)
    res == exp_res && res_flags == exp_flags)
    else report_fail($sformatf("res %h flags %b, expected %h flags %b", res, res_flags,
                               exp_res, exp_flags));

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      issue_valid <= 1'b0;
      a_src <= SRC_PORT;
      b_src <= SRC_PORT;
      f_src <= SRC_PORT;
      ext_res <= rnd64();  // The neighbouring lane keeps producing
      ext_flags <= flags_t'($random(seed));
    end
  endtask

  task automatic issue(input opcode_t op, input data_t a, input data_t b, input flags_t f,
                       input fwd_src_t sa, input fwd_src_t sb, input fwd_src_t sf);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_op <= op;
    a_val <= a;
    b_val <= b;
    flags_val <= f;
    a_src <= sa;
    b_src <= sb;
    f_src <= sf;
    ext_res <= rnd64();
    ext_flags <= flags_t'($random(seed));
  endtask

  task automatic random_ops(input int n, input bit lsh, input bit any_src);
    opcode_t op;
    data_t a, b;
    repeat (n) begin
      op = lsh ? lsh_ops[$unsigned($random(seed)) % 9] : arith_ops[$unsigned($random(seed)) % 7];
      a = rnd64();
      b = (lsh && op >= OP_SHL64) ? data_t'($unsigned($random(seed)) % 128) : rnd64();
      if (($random(seed) & 7) == 0) b = a;  // Equal operands reach the zero flag
      if (any_src)
        issue(op, a, b, flags_t'($random(seed)), fwd_src_t'($unsigned($random(seed)) % 5),
              fwd_src_t'($unsigned($random(seed)) % 5), fwd_src_t'($unsigned($random(seed)) % 5));
      else
        issue(op, a, b, flags_t'($random(seed)), SRC_PORT, SRC_PORT, SRC_PORT);
      if (($random(seed) & 3) == 0) idle(1);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d tests run, %0d checks failed", tests_run, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic end_test(input string name, input int err_start);
    int waited;
    waited = 0;
    idle(2);
    while (issued != retired && waited < 20) begin
      idle(1);
      waited++;
    end
    if (issued != retired) begin
      $display("Timeout: results of test %s never all came back", name);
      errors++;
    end else begin
      tests_run++;
      $display("Test %s done with %0d errors", name, errors - err_start);
    end
  endtask

  initial begin
    int err_start;
    rst_n <= 1'b0;
    issue_valid <= 1'b0;
    issue_op <= OP_ADD64;
    {a_val, b_val, ext_res} <= '0;
    {flags_val, ext_flags} <= '0;
    a_src <= SRC_PORT;
    b_src <= SRC_PORT;
    f_src <= SRC_PORT;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    err_start = errors;
    idle(4);
    end_test("reset_state", err_start);
    err_start = errors;
    repeat (8) issue(OP_ADD64, rnd64(), rnd64(), '0, SRC_PORT, SRC_PORT, SRC_PORT);
    idle(3);
    issue(OP_SUB64, rnd64(), rnd64(), '0, SRC_PORT, SRC_PORT, SRC_PORT);
    end_test("latency", err_start);
    err_start = errors;
    random_ops(60, 1'b0, 1'b0);
    end_test("arith_compare", err_start);
    err_start = errors;
    random_ops(60, 1'b1, 1'b0);
    end_test("logic_shift", err_start);
    err_start = errors;
    repeat (6) begin
      issue(OP_ADD64, 64'hffff_ffff_ffff_ff00 | rnd64(), rnd64(), '0,
            SRC_PORT, SRC_PORT, SRC_PORT);
      idle(1);
      issue(OP_ADC64, '0, rnd64(), '0, SRC_OWN, SRC_PORT, SRC_OWN);  // Carry from two back
      idle(2);
      issue(OP_SUB32, rnd64(), '0, '0, SRC_PORT, SRC_OWN_OLD, SRC_PORT);
      issue(OP_XOR, '0, '0, '0, SRC_EXT, SRC_EXT_OLD, SRC_EXT);
      issue(OP_ADC64, '0, '0, '0, SRC_EXT_OLD, SRC_EXT, SRC_EXT_OLD);
    end
    random_ops(40, 1'b0, 1'b1);
    random_ops(40, 1'b1, 1'b1);
    end_test("forwarding", err_start);
    err_start = errors;
    issue(OP_ADD64, rnd64(), rnd64(), '0, SRC_PORT, SRC_PORT, SRC_PORT);
    issue(opcode_t'(8'hff), rnd64(), rnd64(), '0, SRC_PORT, SRC_PORT, SRC_PORT);
    issue(opcode_t'(8'h00), rnd64(), rnd64(), '0, SRC_PORT, SRC_PORT, SRC_PORT);
    idle(1);
    issue(opcode_t'(8'h13), rnd64(), rnd64(), 5'b01111, SRC_PORT, SRC_PORT, SRC_PORT);
    end_test("illegal_opcode", err_start);
    finish_run();
  end

endmodule

//--- sim.f
+incdir+hw
hw/int_alu_pkg.sv
hw/operand_forward.sv
hw/op_decode.sv
hw/alu_exec.sv
hw/int_alu_lane.sv
bench/int_alu_lane_tb.sv

//--- Bender.yml
package:
  name: int_alu_lane

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/int_alu_pkg.sv
      - hw/operand_forward.sv
      - hw/op_decode.sv
      - hw/alu_exec.sv
      - hw/int_alu_lane.sv
  - target: simulation
    files:
      - bench/int_alu_lane_tb.sv
